// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_debug_unit
FILELIST  ?= debug_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== debug_unit.f ====
rtl/du_pkg.sv
rtl/du_master.sv
rtl/du_imem_loader.sv
rtl/du_regfile_tx.sv
rtl/du_dmem_tx.sv
rtl/debug_unit_top.sv
sim/tb_debug_unit.sv

// ==== rtl/debug_unit_top.sv ====
`timescale 1ns/1ns
// Debug unit top level
// Master plus loader and the two senders, with the transmit sources merged

module debug_unit_top
    import du_pkg::*;
(
    input  logic                    i_rst,
    input  logic                    clk,
    input  du_rx_t                  i_rx,
    input  logic                    i_tx_done,
    input  logic [NB_PC-1:0]        i_pc,
    input  logic [NB_REG-1:0]       i_regfile_data,
    input  logic [NB_DMEM_DATA-1:0] i_dmem_data,
    output du_tx_t                  o_tx,
    output logic                    o_cpu_en,
    output du_imem_wr_t             o_imem_wr,
    output du_rf_rd_t               o_rf_rd,
    output du_dmem_rd_t             o_dmem_rd
);

    du_start_t start;
    du_done_t  done;
    du_tx_t    master_tx;
    du_tx_t    rf_tx;
    du_tx_t    dmem_tx;
    logic      load_done;
    logic      regs_done;
    logic      dmem_done;

    assign done = '{load: load_done, regs: regs_done, dmem: dmem_done};

    // Idle sources drive all zeros, so a plain OR merges them
    assign o_tx = du_tx_t'(master_tx | rf_tx | dmem_tx);

    du_master u_du_master (
        .i_rst     (i_rst),
        .clk       (clk),
        .i_rx      (i_rx),
        .i_tx_done (i_tx_done),
        .i_done    (done),
        .o_start   (start),
        .o_tx      (master_tx),
        .o_cpu_en  (o_cpu_en)
    );

    du_imem_loader u_du_imem_loader (
        .i_rst     (i_rst),
        .clk       (clk),
        .i_start   (start.load),
        .i_rx      (i_rx),
        .o_done    (load_done),
        .o_imem_wr (o_imem_wr)
    );

    du_regfile_tx u_du_regfile_tx (
        .i_rst          (i_rst),
        .clk            (clk),
        .i_start        (start.regs),
        .i_pc           (i_pc),
        .i_regfile_data (i_regfile_data),
        .i_tx_done      (i_tx_done),
        .o_rf_rd        (o_rf_rd),
        .o_tx           (rf_tx),
        .o_done         (regs_done)
    );

    du_dmem_tx u_du_dmem_tx (
        .i_rst       (i_rst),
        .clk         (clk),
        .i_start     (start.dmem),
        .i_dmem_data (i_dmem_data),
        .i_tx_done   (i_tx_done),
        .o_dmem_rd   (o_dmem_rd),
        .o_tx        (dmem_tx),
        .o_done      (dmem_done)
    );

    a_one_tx_source: assert property (@(posedge clk) disable iff (i_rst)
        $onehot0({master_tx.wr, rf_tx.wr, dmem_tx.wr}));

endmodule

// ==== rtl/du_dmem_tx.sv ====
`timescale 1ns/1ns
// Data memory sender
// Reads DMEM_WORDS words and sends each as four bytes, LSB first

module du_dmem_tx
    import du_pkg::*;
(
    input  logic                    i_rst,
    input  logic                    clk,
    input  logic                    i_start,
    input  logic [NB_DMEM_DATA-1:0] i_dmem_data,
    input  logic                    i_tx_done,
    output du_dmem_rd_t             o_dmem_rd,
    output du_tx_t                  o_tx,
    output logic                    o_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_LATCH,
        ST_SEND,
        ST_WAIT
    } state_t;

    state_t                   state_q;
    // One bit wider than the address so an overrun would be visible
    logic [DMEM_ADDR_WIDTH:0] word_cnt_q;
    logic [1:0]               byte_idx_q;
    logic                     done_q;
    logic [NB_DMEM_DATA-1:0]  word_q;
    logic                     send;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q    <= ST_IDLE;
            word_cnt_q <= '0;
            byte_idx_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin
                        word_cnt_q <= '0;
                        byte_idx_q <= '0;
                        state_q    <= ST_READ;
                    end
                end
                ST_READ:  state_q <= ST_LATCH;
                ST_LATCH: state_q <= ST_SEND;
                ST_SEND:  state_q <= ST_WAIT;
                ST_WAIT: begin
                    if (i_tx_done) begin
                        byte_idx_q <= byte_idx_q + 1'b1;
                        if (byte_idx_q != 2'd3) begin
                            state_q <= ST_SEND;
                        end else if (word_cnt_q == (DMEM_ADDR_WIDTH + 1)'(DMEM_WORDS - 1)) begin
                            done_q  <= 1'b1;
                            state_q <= ST_IDLE;
                        end else begin
                            word_cnt_q <= word_cnt_q + 1'b1;
                            state_q    <= ST_READ;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_LATCH) begin
            word_q <= i_dmem_data;
        end else if (state_q == ST_WAIT && i_tx_done) begin
            word_q <= word_q >> NB_UART_DATA;
        end
    end

    assign send      = (state_q == ST_SEND);
    assign o_tx      = '{wr: send, data: send ? word_q[NB_UART_DATA-1:0] : '0};
    assign o_dmem_rd = '{rd: state_q == ST_READ, addr: word_cnt_q[DMEM_ADDR_WIDTH-1:0]};
    assign o_done    = done_q;

    a_addr_bound: assert property (@(posedge clk) disable iff (i_rst)
        word_cnt_q <= (DMEM_ADDR_WIDTH + 1)'(DMEM_WORDS - 1));

endmodule

// ==== rtl/du_imem_loader.sv ====
`timescale 1ns/1ns
// Instruction memory loader
// Takes a word count, then packs little-endian bytes into words and writes them

module du_imem_loader
    import du_pkg::*;
(
    input  logic        i_rst,
    input  logic        clk,
    input  logic        i_start,
    input  du_rx_t      i_rx,
    output logic        o_done,
    output du_imem_wr_t o_imem_wr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COUNT,
        ST_DATA,
        ST_LAST
    } state_t;

    state_t                     state_q;
    logic [NB_UART_DATA-1:0]    n_words_q;
    logic [IMEM_ADDR_WIDTH-1:0] waddr_q;
    logic [IMEM_ADDR_WIDTH-1:0] last_addr;
    logic [1:0]                 byte_idx_q;
    logic                       done_q;
    logic                       wen_q;
    logic [NB_INSTR-1:0]        shift_q;
    logic [NB_INSTR-1:0]        word_next;
    logic [IMEM_ADDR_WIDTH-1:0] wr_addr_q;
    logic [NB_INSTR-1:0]        wr_data_q;

    // New byte enters the top lane, so the first byte ends up lowest
    assign word_next = {i_rx.data, shift_q[NB_INSTR-1:NB_UART_DATA]};
    assign last_addr = IMEM_ADDR_WIDTH'(n_words_q - 1'b1);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q    <= ST_IDLE;
            n_words_q  <= '0;
            waddr_q    <= '0;
            byte_idx_q <= '0;
            done_q     <= 1'b0;
            wen_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            wen_q  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin
                        state_q <= ST_COUNT;
                    end
                end
                ST_COUNT: begin
                    if (i_rx.valid) begin
                        n_words_q  <= i_rx.data;
                        waddr_q    <= '0;
                        byte_idx_q <= '0;
                        if (i_rx.data == '0) begin
                            done_q  <= 1'b1;
                            state_q <= ST_IDLE;
                        end else begin
                            state_q <= ST_DATA;
                        end
                    end
                end
                ST_DATA: begin
                    if (i_rx.valid) begin
                        byte_idx_q <= byte_idx_q + 1'b1;
                        if (byte_idx_q == 2'd3) begin
                            wen_q   <= 1'b1;
                            waddr_q <= waddr_q + 1'b1;
                            if (waddr_q == last_addr) begin
                                state_q <= ST_LAST;
                            end
                        end
                    end
                end
                // Last write is on the bus this cycle
                ST_LAST: begin
                    done_q  <= 1'b1;
                    state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_DATA && i_rx.valid) begin
            shift_q <= word_next;
            if (byte_idx_q == 2'd3) begin
                wr_data_q <= word_next;
                wr_addr_q <= waddr_q;
            end
        end
    end

    assign o_done    = done_q;
    assign o_imem_wr = '{wen: wen_q, addr: wr_addr_q, data: wr_data_q};

    a_addr_in_range: assert property (@(posedge clk) disable iff (i_rst)
        o_imem_wr.wen |-> (o_imem_wr.addr < n_words_q));

endmodule

// ==== rtl/du_master.sv ====
`timescale 1ns/1ns
// Debug unit master
// Decodes host commands, owns the CPU enable and sends the acknowledge byte

module du_master
    import du_pkg::*;
(
    input  logic      i_rst,
    input  logic      clk,
    input  du_rx_t    i_rx,
    input  logic      i_tx_done,
    input  du_done_t  i_done,
    output du_start_t o_start,
    output du_tx_t    o_tx,
    output logic      o_cpu_en
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RUN,
        ST_BUSY,
        ST_ACK,
        ST_ACK_WAIT
    } state_t;

    state_t                  state_q;
    du_start_t               start_q;
    logic                    cpu_en_q;
    logic [NB_UART_DATA-1:0] ack_q;
    logic                    ack_send;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q  <= ST_IDLE;
            start_q  <= '0;
            cpu_en_q <= 1'b0;
        end else begin
            start_q <= '0;
            case (state_q)
                ST_IDLE: begin
                    if (i_rx.valid) begin
                        case (i_rx.data)
                            CMD_LOAD: begin
                                start_q.load <= 1'b1;
                                state_q      <= ST_BUSY;
                            end
                            CMD_REGS: begin
                                start_q.regs <= 1'b1;
                                state_q      <= ST_BUSY;
                            end
                            CMD_DMEM: begin
                                start_q.dmem <= 1'b1;
                                state_q      <= ST_BUSY;
                            end
                            CMD_GO: begin
                                cpu_en_q <= 1'b1;
                                state_q  <= ST_RUN;
                            end
                            // Already halted so nothing to do
                            CMD_HALT: state_q <= ST_IDLE;
                            CMD_STEP: begin
                                cpu_en_q <= 1'b1;
                                state_q  <= ST_BUSY;
                            end
                            default: begin
                                ack_q   <= ACK_BAD;
                                state_q <= ST_ACK;
                            end
                        endcase
                    end
                end
                // Only halt is heard while the CPU runs
                ST_RUN: begin
                    if (i_rx.valid && i_rx.data == CMD_HALT) begin
                        cpu_en_q <= 1'b0;
                        state_q  <= ST_IDLE;
                    end
                end
                // A step ends after one enabled cycle and a worker ends on its done pulse
                ST_BUSY: begin
                    if (cpu_en_q || (|i_done)) begin
                        cpu_en_q <= 1'b0;
                        ack_q    <= ACK_OK;
                        state_q  <= ST_ACK;
                    end
                end
                ST_ACK: state_q <= ST_ACK_WAIT;
                ST_ACK_WAIT: begin
                    if (i_tx_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign ack_send = (state_q == ST_ACK);
    assign o_tx     = '{wr: ack_send, data: ack_send ? ack_q : '0};
    assign o_start  = start_q;
    assign o_cpu_en = cpu_en_q;

    a_one_start: assert property (@(posedge clk) disable iff (i_rst) $onehot0(o_start));
    a_no_start_running: assert property (@(posedge clk) disable iff (i_rst)
        (|o_start) |-> !o_cpu_en);

endmodule

// ==== rtl/du_pkg.sv ====
// Debug unit shared definitions
// Word widths, memory sizes, host command bytes and the bus structs

package du_pkg;

    // Word widths
    localparam int NB_PC        = 32;
    localparam int NB_REG       = 32;
    localparam int NB_INSTR     = 32;
    localparam int NB_DMEM_DATA = 32;
    localparam int NB_UART_DATA = 8;

    // Memory and register file sizes
    localparam int IMEM_ADDR_WIDTH = 8;
    localparam int NB_REG_ADDR     = 5;
    localparam int N_REGS          = 32;
    localparam int DMEM_ADDR_WIDTH = 4;
    localparam int DMEM_WORDS      = 16;

    // ASCII host commands
    localparam logic [NB_UART_DATA-1:0] CMD_LOAD = 8'h4C;
    localparam logic [NB_UART_DATA-1:0] CMD_REGS = 8'h52;
    localparam logic [NB_UART_DATA-1:0] CMD_DMEM = 8'h44;
    localparam logic [NB_UART_DATA-1:0] CMD_GO   = 8'h47;
    localparam logic [NB_UART_DATA-1:0] CMD_HALT = 8'h48;
    localparam logic [NB_UART_DATA-1:0] CMD_STEP = 8'h53;

    // Acknowledge bytes 'K' and '?'
    localparam logic [NB_UART_DATA-1:0] ACK_OK  = 8'h4B;
    localparam logic [NB_UART_DATA-1:0] ACK_BAD = 8'h3F;

    typedef struct packed {
        logic                    valid;
        logic [NB_UART_DATA-1:0] data;
    } du_rx_t;

    typedef struct packed {
        logic                    wr;
        logic [NB_UART_DATA-1:0] data;
    } du_tx_t;

    typedef struct packed {
        logic                       wen;
        logic [IMEM_ADDR_WIDTH-1:0] addr;
        logic [NB_INSTR-1:0]        data;
    } du_imem_wr_t;

    typedef struct packed {
        logic                   rd;
        logic [NB_REG_ADDR-1:0] addr;
    } du_rf_rd_t;

    typedef struct packed {
        logic                       rd;
        logic [DMEM_ADDR_WIDTH-1:0] addr;
    } du_dmem_rd_t;

    typedef struct packed {
        logic load;
        logic regs;
        logic dmem;
    } du_start_t;

    typedef struct packed {
        logic load;
        logic regs;
        logic dmem;
    } du_done_t;

endpackage

// ==== rtl/du_regfile_tx.sv ====
`timescale 1ns/1ns
// Register file sender
// Sends the PC, then registers 0 to 31, four bytes each, LSB first

module du_regfile_tx
    import du_pkg::*;
(
    input  logic              i_rst,
    input  logic              clk,
    input  logic              i_start,
    input  logic [NB_PC-1:0]  i_pc,
    input  logic [NB_REG-1:0] i_regfile_data,
    input  logic              i_tx_done,
    output du_rf_rd_t         o_rf_rd,
    output du_tx_t            o_tx,
    output logic              o_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_LATCH,
        ST_SEND,
        ST_WAIT
    } state_t;

    state_t                 state_q;
    logic                   pc_phase_q;
    logic [NB_REG_ADDR-1:0] reg_idx_q;
    logic [1:0]             byte_idx_q;
    logic                   done_q;
    logic                   tx_pend_q;
    logic [NB_REG-1:0]      word_q;
    logic                   send;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q    <= ST_IDLE;
            pc_phase_q <= 1'b0;
            reg_idx_q  <= '0;
            byte_idx_q <= '0;
            done_q     <= 1'b0;
            tx_pend_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (send) begin
                tx_pend_q <= 1'b1;
            end else if (i_tx_done) begin
                tx_pend_q <= 1'b0;
            end
            case (state_q)
                // PC needs no read and is sent at once
                ST_IDLE: begin
                    if (i_start) begin
                        pc_phase_q <= 1'b1;
                        reg_idx_q  <= '0;
                        byte_idx_q <= '0;
                        state_q    <= ST_SEND;
                    end
                end
                ST_READ:  state_q <= ST_LATCH;
                ST_LATCH: state_q <= ST_SEND;
                ST_SEND:  state_q <= ST_WAIT;
                ST_WAIT: begin
                    if (i_tx_done) begin
                        byte_idx_q <= byte_idx_q + 1'b1;
                        if (byte_idx_q != 2'd3) begin
                            state_q <= ST_SEND;
                        end else if (pc_phase_q) begin
                            pc_phase_q <= 1'b0;
                            state_q    <= ST_READ;
                        end else if (reg_idx_q == NB_REG_ADDR'(N_REGS - 1)) begin
                            done_q  <= 1'b1;
                            state_q <= ST_IDLE;
                        end else begin
                            reg_idx_q <= reg_idx_q + 1'b1;
                            state_q   <= ST_READ;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Word holder shifts down one byte per finished write
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && i_start) begin
            word_q <= NB_REG'(i_pc);
        end else if (state_q == ST_LATCH) begin
            word_q <= i_regfile_data;
        end else if (state_q == ST_WAIT && i_tx_done) begin
            word_q <= word_q >> NB_UART_DATA;
        end
    end

    assign send    = (state_q == ST_SEND);
    assign o_tx    = '{wr: send, data: send ? word_q[NB_UART_DATA-1:0] : '0};
    assign o_rf_rd = '{rd: state_q == ST_READ, addr: reg_idx_q};
    assign o_done  = done_q;

    a_one_outstanding: assert property (@(posedge clk) disable iff (i_rst)
        o_tx.wr |-> !tx_pend_q);

endmodule

// ==== sim/tb_debug_unit.sv ====
`timescale 1ns/1ns
// Testbench for the debug unit
// Models of the CPU register file, data memory and UART transmitter
// Directed tests for load, dumps, run control, step and bad commands

module tb_debug_unit import du_pkg::*; ();

    localparam int CLK_HALF_NS = 20;
    localparam int BYTE_TIMEOUT = 40;
    // Longest test is 132 bytes at up to 9 cycles each, plus the rest
    localparam int WATCHDOG_NS = 200_000;
    localparam logic [NB_PC-1:0] PC_VALUE = 32'h0040_00A8;
    localparam logic [NB_INSTR-1:0] FW_WORDS [3] = '{32'h44332211, 32'hDEADBEEF, 32'h0BADF00D};

    logic                    clk = 1'b0;
    logic                    i_rst;
    du_rx_t                  i_rx;
    logic                    i_tx_done;
    logic [NB_PC-1:0]        i_pc;
    logic [NB_REG-1:0]       i_regfile_data;
    logic [NB_DMEM_DATA-1:0] i_dmem_data;
    du_tx_t                  o_tx;
    logic                    o_cpu_en;
    du_imem_wr_t             o_imem_wr;
    du_rf_rd_t               o_rf_rd;
    du_dmem_rd_t             o_dmem_rd;

    integer                  seed = 32'hbd9415b6;
    int                      errors = 0;
    int                      checks = 0;
    int                      cpu_en_cycles = 0;
    int                      delay;
    logic                    tx_busy = 1'b0;
    logic [NB_UART_DATA-1:0] tx_q[$];
    du_imem_wr_t             wr_q[$];

    debug_unit_top i_dut (
        .i_rst          (i_rst),
        .clk            (clk),
        .i_rx           (i_rx),
        .i_tx_done      (i_tx_done),
        .i_pc           (i_pc),
        .i_regfile_data (i_regfile_data),
        .i_dmem_data    (i_dmem_data),
        .o_tx           (o_tx),
        .o_cpu_en       (o_cpu_en),
        .o_imem_wr      (o_imem_wr),
        .o_rf_rd        (o_rf_rd),
        .o_dmem_rd      (o_dmem_rd)
    );

    initial begin
        forever #CLK_HALF_NS clk = ~clk;
    end

    function automatic logic [NB_REG-1:0] reg_word(input int r);
        return (NB_REG'(r) * 32'h01010101) ^ 32'hA5A5A5A5;
    endfunction

    function automatic logic [NB_DMEM_DATA-1:0] dmem_word(input int a);
        return NB_DMEM_DATA'(a) * 32'h11111111 + 32'd7;
    endfunction

    // Memories answer one cycle after the read strobe
    always begin
        @(posedge clk);
        if (o_rf_rd.rd || o_dmem_rd.rd) begin
            #5;
            i_regfile_data = reg_word(int'(o_rf_rd.addr));
            i_dmem_data    = dmem_word(int'(o_dmem_rd.addr));
        end
    end

    // UART transmitter answers each byte after 1 to 8 cycles
    always begin
        @(posedge clk);
        if (o_tx.wr) begin
            tx_q.push_back(o_tx.data);
            tx_busy = 1'b1;
            delay = 1 + ({$random(seed)} % 8);
            repeat (delay - 1) begin
                @(posedge clk);
                if (o_tx.wr) begin
                    errors++;
                    $display("Second write before the previous byte finished");
                end
            end
            #5 i_tx_done = 1'b1;
            @(posedge clk);
            if (o_tx.wr) begin
                errors++;
                $display("Write in the same cycle as the done pulse");
            end
            #5 i_tx_done = 1'b0;
            tx_busy = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!i_rst && o_imem_wr.wen) begin
            wr_q.push_back(o_imem_wr);
        end
        if (o_cpu_en) begin
            cpu_en_cycles++;
        end
    end

    task automatic check_byte(input string name, input logic [NB_UART_DATA-1:0] exp,
                              input logic [NB_UART_DATA-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_imem_wr(input string name, input du_imem_wr_t exp,
                                 input du_imem_wr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected addr %0d data %h, got addr %0d data %h",
                     name, exp.addr, exp.data, act.addr, act.data);
        end
    endtask

    task automatic check_cpu_en(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %b, got %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAIL %s: expected %0d, got %0d", name, exp, act);
        end
    endtask

    task automatic send_byte(input logic [NB_UART_DATA-1:0] b);
        @(posedge clk);
        #5;
        i_rx.valid = 1'b1;
        i_rx.data  = b;
        @(posedge clk);
        #5;
        i_rx = '0;
    endtask

    task automatic expect_byte(input string name, input logic [NB_UART_DATA-1:0] exp);
        int                      waited;
        logic [NB_UART_DATA-1:0] act;
        waited = 0;
        while (tx_q.size() == 0 && waited < BYTE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_q.size() == 0) begin
            errors++;
            $display("%s: no byte arrived within %0d cycles", name, BYTE_TIMEOUT);
        end else begin
            act = tx_q.pop_front();
            check_byte(name, exp, act);
        end
    endtask

    task automatic expect_word(input string name, input logic [31:0] w);
        for (int k = 0; k < 4; k++) begin
            expect_byte(name, w[8*k +: 8]);
        end
    endtask

    // Master takes no command until the last byte is done
    task automatic wait_tx_idle();
        @(negedge clk);
        while (tx_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic load_firmware(input int n);
        du_imem_wr_t exp;
        wr_q.delete();
        send_byte(CMD_LOAD);
        send_byte(NB_UART_DATA'(n));
        for (int i = 0; i < n; i++) begin
            for (int k = 0; k < 4; k++) begin
                send_byte(FW_WORDS[i][8*k +: 8]);
            end
        end
        expect_byte("load_ack", ACK_OK);
        // All writes are in before the acknowledge
        check_count("load_writes", n, wr_q.size());
        for (int i = 0; i < n && i < wr_q.size(); i++) begin
            exp = '{wen: 1'b1, addr: IMEM_ADDR_WIDTH'(i), data: FW_WORDS[i]};
            check_imem_wr("load_word", exp, wr_q[i]);
        end
        wait_tx_idle();
    endtask

    task automatic dump_registers();
        send_byte(CMD_REGS);
        expect_word("regs_pc", PC_VALUE);
        for (int r = 0; r < N_REGS; r++) begin
            expect_word("regs_data", reg_word(r));
        end
        expect_byte("regs_ack", ACK_OK);
        wait_tx_idle();
    endtask

    task automatic dump_data_memory();
        send_byte(CMD_DMEM);
        for (int a = 0; a < DMEM_WORDS; a++) begin
            expect_word("dmem_data", dmem_word(a));
        end
        expect_byte("dmem_ack", ACK_OK);
        wait_tx_idle();
    endtask

    task automatic run_and_halt();
        check_cpu_en("run_before", 1'b0, o_cpu_en);
        send_byte(CMD_GO);
        check_cpu_en("run_go", 1'b1, o_cpu_en);
        send_byte(CMD_REGS);
        repeat (20) @(negedge clk);
        check_count("run_bytes", 0, tx_q.size());
        check_cpu_en("run_hold", 1'b1, o_cpu_en);
        send_byte(CMD_HALT);
        check_cpu_en("run_halt", 1'b0, o_cpu_en);
        repeat (5) @(negedge clk);
        check_count("halt_bytes", 0, tx_q.size());
    endtask

    task automatic step_and_bad_command();
        cpu_en_cycles = 0;
        send_byte(CMD_STEP);
        expect_byte("step_ack", ACK_OK);
        wait_tx_idle();
        check_count("step_cycles", 1, cpu_en_cycles);
        send_byte(8'h5A);
        expect_byte("bad_ack", ACK_BAD);
        wait_tx_idle();
    endtask

    task automatic outputs_after_reset();
        repeat (4) begin
            @(negedge clk);
            check_cpu_en("reset_cpu_en", 1'b0, o_cpu_en);
            if (o_tx.wr || o_imem_wr.wen || o_rf_rd.rd || o_dmem_rd.rd) begin
                errors++;
                $display("A strobe is high right after reset");
            end
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        i_rst          = 1'b1;
        i_rx           = '0;
        i_tx_done      = 1'b0;
        i_pc           = PC_VALUE;
        i_regfile_data = '0;
        i_dmem_data    = '0;
        repeat (10) @(posedge clk);
        #5 i_rst = 1'b0;
        outputs_after_reset();
        load_firmware(3);
        load_firmware(0);
        dump_registers();
        dump_data_memory();
        run_and_halt();
        step_and_bad_command();
        if (tx_q.size() != 0) begin
            errors++;
            $display("%0d bytes were sent that no test expected", tx_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
